// File: src/trace_cfg.svh
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// FIFO geometry
`define TRACE_DEPTH 8
`define TRACE_CNT_W 4

// Wishbone register map, word addresses
`define TRACE_ADDR_STATUS 4'd0
`define TRACE_ADDR_POP    4'd1
`define TRACE_ADDR_DATA0  4'd2

// Head record spans eight 32-bit data words
`define TRACE_DATA_WORDS 8

// Status register fields
`define TRACE_STATUS_DROP_LSB 16

`endif

// File: src/trace_pkg.sv
package trace_pkg;

    // Machine word: pc, epc, data, cause
    typedef logic [63:0] xlen_t;

    // Instruction word
    typedef logic [31:0] inst_t;

    // Privilege level
    typedef logic [1:0] prv_t;

    // Cycle stamp taken at the FIFO write
    typedef logic [27:0] stamp_t;

    // Unstamped record from a packer
    // {kind, prv, mxl, pc, inst, word_a, word_b}
    typedef logic [227:0] trace_body_t;

    // Stored record, same order as the core trace packet
    // {kind, prv, mxl, stamp, pc, inst, word_a, word_b}
    typedef logic [255:0] trace_rec_t;

    // Wishbone data word
    typedef logic [31:0] wb_word_t;

endpackage

// File: src/retire_packer.sv
module retire_packer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   valid,
    input  trace_pkg::prv_t        prv,
    input  logic [1:0]             misa_mxl,
    input  trace_pkg::xlen_t       pc,
    input  trace_pkg::inst_t       inst,
    input  trace_pkg::xlen_t       rd_data,
    input  trace_pkg::xlen_t       csr_wdata,
    input  trace_pkg::xlen_t       mem_addr,
    input  trace_pkg::xlen_t       mem_rdata,
    input  trace_pkg::xlen_t       mem_wdata,
    input  logic                   mem_req,
    input  logic                   mem_wr,
    output logic                   rec_valid,
    output trace_pkg::trace_body_t rec
);
    import trace_pkg::*;

    xlen_t word_a;
    xlen_t word_b;

    // Memory ops report address and data, others report CSR and rd writes
    always_comb begin
        if (mem_req) begin
            word_a = mem_addr;
            word_b = mem_wr ? mem_wdata : mem_rdata;
        end else begin
            word_a = csr_wdata;
            word_b = rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            rec <= {1'b0, prv, misa_mxl[1], pc, inst, word_a, word_b};
        end
    end

endmodule

// File: src/trap_packer.sv
module trap_packer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   trap_en,
    input  trace_pkg::prv_t        prv,
    input  logic [1:0]             misa_mxl,
    input  trace_pkg::xlen_t       epc,
    input  trace_pkg::xlen_t       mcause,
    input  trace_pkg::xlen_t       mtval,
    output logic                   rec_valid,
    output trace_pkg::trace_body_t rec
);
    import trace_pkg::*;

    trace_body_t body;

    // Kind 1, no instruction word for a trap
    always_comb begin
        body = {1'b1, prv, misa_mxl[1], epc, 32'd0, mcause, mtval};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= trap_en;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_en) begin
            rec <= body;
        end
    end

endmodule

// File: src/trace_buffer.sv
`include "trace_cfg.svh"

module trace_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    retire_valid,
    input  trace_pkg::trace_body_t  retire_rec,
    input  logic                    trap_valid,
    input  trace_pkg::trace_body_t  trap_rec,
    input  logic                    pop,
    output trace_pkg::trace_rec_t   head,
    output logic [`TRACE_CNT_W-1:0] count,
    output logic                    empty,
    output logic [15:0]             drop_count
);
    import trace_pkg::*;

    stamp_t                            cycle_cnt;
    trace_rec_t                        mem [`TRACE_DEPTH];
    logic [$clog2(`TRACE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(`TRACE_DEPTH)-1:0]   rd_ptr;
    trace_body_t                       sel_body;
    trace_rec_t                        stamped;
    logic                              in_valid;
    logic                              full;
    logic                              collide;
    logic                              full_drop;
    logic                              do_wr;
    logic                              do_rd;
    logic [1:0]                        drop_inc;
    logic [16:0]                       drop_sum;

    // Trap wins a collision
    assign in_valid = retire_valid | trap_valid;
    assign collide  = retire_valid & trap_valid;
    assign sel_body = trap_valid ? trap_rec : retire_rec;

    // Stamp goes between the MXL bit and pc
    assign stamped = {sel_body[227:224], cycle_cnt, sel_body[223:0]};

    assign empty = (count == '0);
    assign full  = (count == `TRACE_CNT_W'(`TRACE_DEPTH));

    // A pop in the same cycle does not free a slot for the write
    assign full_drop = in_valid & full;
    assign do_wr     = in_valid & ~full;
    assign do_rd     = pop & ~empty;

    assign head = mem[rd_ptr];

    // Collision and overflow can both drop in one cycle
    assign drop_inc = {1'b0, collide} + {1'b0, full_drop};
    assign drop_sum = {1'b0, drop_count} + {15'd0, drop_inc};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt  <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            drop_count <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Saturates at all ones
            if (drop_sum[16]) begin
                drop_count <= '1;
            end else begin
                drop_count <= drop_sum[15:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= stamped;
        end
    end

endmodule

// File: src/trace_wb_port.sv
`include "trace_cfg.svh"

module trace_wb_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [3:0]              adr,
    input  trace_pkg::wb_word_t     dat_i,
    output trace_pkg::wb_word_t     dat_o,
    output logic                    ack,
    input  trace_pkg::trace_rec_t   head,
    input  logic [`TRACE_CNT_W-1:0] count,
    input  logic                    empty,
    input  logic [15:0]             drop_count,
    output logic                    pop
);
    import trace_pkg::*;

    logic     req;
    logic     data_hit;
    logic [2:0] word_sel;
    wb_word_t status;
    wb_word_t rdata;

    // New access seen, ack goes out on the next edge
    assign req = cyc & stb & ~ack;

    assign data_hit = (adr >= `TRACE_ADDR_DATA0) &&
                      (adr < `TRACE_ADDR_DATA0 + 4'(`TRACE_DATA_WORDS));
    assign word_sel = 3'(adr - `TRACE_ADDR_DATA0);

    always_comb begin
        status = '0;
        status[`TRACE_CNT_W-1:0] = count;
        status[31:`TRACE_STATUS_DROP_LSB] = drop_count;
    end

    // Unmapped reads, pop address included, return zero
    always_comb begin
        if (adr == `TRACE_ADDR_STATUS) begin
            rdata = status;
        end else if (data_hit) begin
            rdata = head[{word_sel, 5'd0} +: 32];
        end else begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            pop <= 1'b0;
        end else begin
            ack <= req;
            pop <= req & we & (adr == `TRACE_ADDR_POP) & ~empty;
        end
    end

    // Write cycles echo the write data
    always_ff @(posedge clk) begin
        if (req) begin
            dat_o <= we ? dat_i : rdata;
        end
    end

endmodule

// File: src/trace_top.sv
`include "trace_cfg.svh"

module trace_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                retire_valid,
    input  trace_pkg::prv_t     prv,
    input  logic [1:0]          misa_mxl,
    input  trace_pkg::xlen_t    pc,
    input  trace_pkg::inst_t    inst,
    input  trace_pkg::xlen_t    rd_data,
    input  trace_pkg::xlen_t    csr_wdata,
    input  trace_pkg::xlen_t    mem_addr,
    input  trace_pkg::xlen_t    mem_rdata,
    input  trace_pkg::xlen_t    mem_wdata,
    input  logic                mem_req,
    input  logic                mem_wr,
    input  logic                trap_en,
    input  trace_pkg::xlen_t    epc,
    input  trace_pkg::xlen_t    mcause,
    input  trace_pkg::xlen_t    mtval,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [3:0]          adr,
    input  trace_pkg::wb_word_t dat_i,
    output trace_pkg::wb_word_t dat_o,
    output logic                ack
);
    import trace_pkg::*;

    logic                    retire_rec_valid;
    trace_body_t             retire_rec;
    logic                    trap_rec_valid;
    trace_body_t             trap_rec;
    trace_rec_t              head;
    logic [`TRACE_CNT_W-1:0] count;
    logic                    empty;
    logic [15:0]             drop_count;
    logic                    pop;

    retire_packer u_retire (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (retire_valid),
        .prv       (prv),
        .misa_mxl  (misa_mxl),
        .pc        (pc),
        .inst      (inst),
        .rd_data   (rd_data),
        .csr_wdata (csr_wdata),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_req   (mem_req),
        .mem_wr    (mem_wr),
        .rec_valid (retire_rec_valid),
        .rec       (retire_rec)
    );

    trap_packer u_trap (
        .clk       (clk),
        .rst_n     (rst_n),
        .trap_en   (trap_en),
        .prv       (prv),
        .misa_mxl  (misa_mxl),
        .epc       (epc),
        .mcause    (mcause),
        .mtval     (mtval),
        .rec_valid (trap_rec_valid),
        .rec       (trap_rec)
    );

    trace_buffer u_buf (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire_valid (retire_rec_valid),
        .retire_rec   (retire_rec),
        .trap_valid   (trap_rec_valid),
        .trap_rec     (trap_rec),
        .pop          (pop),
        .head         (head),
        .count        (count),
        .empty        (empty),
        .drop_count   (drop_count)
    );

    trace_wb_port u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .ack        (ack),
        .head       (head),
        .count      (count),
        .empty      (empty),
        .drop_count (drop_count),
        .pop        (pop)
    );

endmodule

// File: tb/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

// File: tb/trace_sva.sv
`include "trace_cfg.svh"

module trace_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    cyc,
    input logic                    stb,
    input logic                    ack,
    input logic [`TRACE_CNT_W-1:0] count,
    input logic                    empty,
    input logic                    pop
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
        else begin
            fail_cnt++;
            $error("ack high for more than one cycle");
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack |-> (cyc && stb))
        else begin
            fail_cnt++;
            $error("ack outside of an active bus cycle");
        end

    count_bound: assert property (@(posedge clk) disable iff (!rst_n) count <= `TRACE_DEPTH)
        else begin
            fail_cnt++;
            $error("FIFO count above depth");
        end

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else begin
            fail_cnt++;
            $error("pop while FIFO empty");
        end

endmodule

// File: tb/tb_trace.sv
`include "trace_cfg.svh"

module tb_trace;
    timeunit 1ns;
    timeprecision 100ps;
    import trace_pkg::*;

    localparam int N_BATCH_RET  = 5;
    localparam int N_BATCH_TRAP = 3;
    localparam int BATCH_LEN    = 4;
    // Roughly 30 cycles per record for event, status, eight words and pop
    localparam int N_RECORDS    = (N_BATCH_RET + N_BATCH_TRAP) * BATCH_LEN + 1 + 12;
    localparam int CYCLE_LIMIT  = N_RECORDS * 30 + 200;

    logic        clk;
    logic        rst_n;
    logic        retire_valid;
    prv_t        prv;
    logic [1:0]  misa_mxl;
    xlen_t       pc;
    inst_t       inst;
    xlen_t       rd_data;
    xlen_t       csr_wdata;
    xlen_t       mem_addr;
    xlen_t       mem_rdata;
    xlen_t       mem_wdata;
    logic        mem_req;
    logic        mem_wr;
    logic        trap_en;
    xlen_t       epc;
    xlen_t       mcause;
    xlen_t       mtval;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    wb_word_t    dat_i;
    wb_word_t    dat_o;
    logic        ack;

    int          seed;
    int          cycles;
    stamp_t      cyc_mirror;
    trace_rec_t  exp_q[$];
    logic [15:0] drops;
    logic [15:0] drops_before;
    wb_word_t    rd_word;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    trace_top DUT (.*);

    bind trace_wb_port trace_sva u_sva (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .ack   (ack),
        .count (count),
        .empty (empty),
        .pop   (pop)
    );

    // Mirror of the buffer's cycle counter
    always @(posedge clk) begin
        if (!rst_n) begin
            cyc_mirror <= '0;
        end else begin
            cyc_mirror <= cyc_mirror + 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic xlen_t rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    // Called 10 ns after an edge, returns 10 ns after the edge that ends the access
    task automatic wb_access(input logic w, input logic [3:0] a, input wb_word_t d,
                             output wb_word_t q);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        dat_i = d;
        do begin
            @(posedge clk);
            #10;
        end while (!ack);
        q = dat_o;
        @(posedge clk);
        #10;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        check_val("wb_ack_single", 64'd0, {63'd0, ack});
    endtask

    task automatic wb_read(input logic [3:0] a, output wb_word_t q);
        wb_access(1'b0, a, '0, q);
    endtask

    task automatic wb_write(input logic [3:0] a, input wb_word_t d);
        wb_word_t unused;
        wb_access(1'b1, a, d, unused);
    endtask

    task automatic note_drop();
        if (drops != 16'hffff) begin
            drops = drops + 1'b1;
        end
    endtask

    task automatic send_event(input bit ret, input bit trp);
        logic [31:0] r;
        stamp_t      st;
        xlen_t       wa;
        xlen_t       wb;
        trace_rec_t  rec;
        r         = $random(seed);
        prv       = r[1:0];
        misa_mxl  = r[3:2];
        mem_req   = (r[7:4] % 3) != 0;
        mem_wr    = (r[7:4] % 3) == 1;
        pc        = rand64();
        inst      = $random(seed);
        rd_data   = rand64();
        csr_wdata = rand64();
        mem_addr  = rand64();
        mem_rdata = rand64();
        mem_wdata = rand64();
        epc       = rand64();
        mcause    = rand64();
        mtval     = rand64();
        retire_valid = ret;
        trap_en      = trp;
        // Write lands two edges on, one count past the mirror now
        st = cyc_mirror + 1'b1;
        if (trp) begin
            rec = {1'b1, prv, misa_mxl[1], st, epc, 32'd0, mcause, mtval};
        end else begin
            wa = mem_req ? mem_addr : csr_wdata;
            wb = !mem_req ? rd_data : (mem_wr ? mem_wdata : mem_rdata);
            rec = {1'b0, prv, misa_mxl[1], st, pc, inst, wa, wb};
        end
        if (ret && trp) begin
            note_drop();
        end
        if (exp_q.size() == `TRACE_DEPTH) begin
            note_drop();
        end else begin
            exp_q.push_back(rec);
        end
        @(posedge clk);
        #10;
        retire_valid = 1'b0;
        trap_en      = 1'b0;
    endtask

    task automatic settle();
        repeat (2) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic check_status(input string name);
        wb_word_t s;
        wb_read(`TRACE_ADDR_STATUS, s);
        check_val({name, "_count"}, 64'(exp_q.size()), 64'(s[`TRACE_CNT_W-1:0]));
        check_val({name, "_drops"}, 64'(drops), 64'(s[31:16]));
    endtask

    task automatic check_head(input string name);
        trace_rec_t exp;
        wb_word_t   w;
        check_status(name);
        exp = exp_q[0];
        for (int k = 0; k < `TRACE_DATA_WORDS; k++) begin
            wb_read(`TRACE_ADDR_DATA0 + 4'(k), w);
            check_val($sformatf("%s_w%0d", name, k), 64'(exp[32*k +: 32]), 64'(w));
        end
        wb_write(`TRACE_ADDR_POP, '0);
        void'(exp_q.pop_front());
    endtask

    task automatic drain(input string name);
        while (exp_q.size() != 0) begin
            check_head(name);
        end
    endtask

    task automatic run_batch(input string name, input int n, input bit ret, input bit trp);
        int gap;
        for (int i = 0; i < n; i++) begin
            send_event(ret, trp);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #10;
            end
        end
        settle();
        drain(name);
    endtask

    initial begin
        retire_valid = 1'b0;
        trap_en   = 1'b0;
        prv       = '0;
        misa_mxl  = '0;
        pc        = '0;
        inst      = '0;
        rd_data   = '0;
        csr_wdata = '0;
        mem_addr  = '0;
        mem_rdata = '0;
        mem_wdata = '0;
        mem_req   = 1'b0;
        mem_wr    = 1'b0;
        epc       = '0;
        mcause    = '0;
        mtval     = '0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_i     = '0;
        seed      = 55144;
        drops     = '0;

        @(posedge rst_n);
        @(posedge clk);
        #10;

        check_status("reset");
        // Stale or empty head, value not checked
        wb_read(`TRACE_ADDR_DATA0, rd_word);
        wb_write(`TRACE_ADDR_POP, '0);
        check_status("reset_pop");

        repeat (N_BATCH_RET) run_batch("retire", BATCH_LEN, 1'b1, 1'b0);
        repeat (N_BATCH_TRAP) run_batch("trap", BATCH_LEN, 1'b0, 1'b1);

        // One collision adds exactly one drop
        drops_before = drops;
        run_batch("collide", 1, 1'b1, 1'b1);
        wb_read(`TRACE_ADDR_STATUS, rd_word);
        check_val("collide_drop", 64'(drops_before + 16'd1), 64'(rd_word[31:16]));

        // Overflow, twelve events into eight slots
        drops_before = drops;
        for (int i = 0; i < 12; i++) begin
            send_event(1'b1, 1'b0);
        end
        settle();
        wb_read(`TRACE_ADDR_STATUS, rd_word);
        check_val("fill_count", 64'd8, 64'(rd_word[`TRACE_CNT_W-1:0]));
        check_val("fill_drops", 64'(drops_before + 16'd4), 64'(rd_word[31:16]));
        drain("fill");

        wb_read(4'd12, rd_word);
        check_val("wb_unmapped", 64'd0, 64'(rd_word));
        wb_read(`TRACE_ADDR_POP, rd_word);
        check_val("wb_pop_read", 64'd0, 64'(rd_word));
        wb_write(`TRACE_ADDR_STATUS, $random(seed));
        check_status("wb_status");

        if (DUT.u_wb.u_sva.fail_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Assertion failures: %0d", DUT.u_wb.u_sva.fail_cnt);
            $display("TB FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: files.f
+incdir+src
src/trace_pkg.sv
src/retire_packer.sv
src/trap_packer.sv
src/trace_buffer.sv
src/trace_wb_port.sv
src/trace_top.sv
tb/tb_clock.sv
tb/trace_sva.sv
tb/tb_trace.sv

// File: Makefile
# Verilator build and run for the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trace
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
